// File: common/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Byte address into the AXI-lite space
`define BRIDGE_ADDR_W 32

// Memory message data and AXI data share one width
`define BRIDGE_DATA_W 32
`define BRIDGE_STRB_W 4

// Request ports in front of the arbiter
`define BRIDGE_NUM_PORTS 2

`endif

// File: common/mem_msg_pkg.sv
`include "bridge_defines.svh"

package mem_msg_pkg;

  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_opcode_e;

  // Access size in bytes, log2 encoded
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_size_e;

  typedef enum logic {
    e_resp_ok    = 1'b0,
    e_resp_error = 1'b1
  } mem_resp_e;

  typedef struct packed {
    mem_opcode_e               opcode;
    mem_size_e                 size;
    logic [`BRIDGE_ADDR_W-1:0] addr;
  } mem_fwd_header_s;

  // Request header echoed back with the bus response
  typedef struct packed {
    mem_opcode_e               opcode;
    mem_size_e                 size;
    logic [`BRIDGE_ADDR_W-1:0] addr;
    mem_resp_e                 resp;
  } mem_rev_header_s;

endpackage

// File: common/axil_pkg.sv
package axil_pkg;

  typedef enum logic [1:0] {
    e_axil_okay   = 2'b00,
    e_axil_exokay = 2'b01,
    e_axil_slverr = 2'b10,
    e_axil_decerr = 2'b11
  } axil_resp_e;

  // Single outstanding master sequence
  typedef enum logic [2:0] {
    e_st_idle,
    e_st_write_req,
    e_st_write_resp,
    e_st_read_req,
    e_st_read_resp,
    e_st_rev_out
  } axil_state_e;

endpackage

// File: common/mem_link_if.sv
`timescale 1ns/100ps
`include "bridge_defines.svh"

interface mem_link_if;

  // Forward channel, request toward memory
  mem_msg_pkg::mem_fwd_header_s fwd_header;
  logic [`BRIDGE_DATA_W-1:0]    fwd_data;
  logic                         fwd_v;
  logic                         fwd_ready_and;

  // Reverse channel, response back to requester
  mem_msg_pkg::mem_rev_header_s rev_header;
  logic [`BRIDGE_DATA_W-1:0]    rev_data;
  logic                         rev_v;
  logic                         rev_ready_and;

  modport client (
    output fwd_header,
    output fwd_data,
    output fwd_v,
    input  fwd_ready_and,
    input  rev_header,
    input  rev_data,
    input  rev_v,
    output rev_ready_and
  );

  modport server (
    input  fwd_header,
    input  fwd_data,
    input  fwd_v,
    output fwd_ready_and,
    output rev_header,
    output rev_data,
    output rev_v,
    input  rev_ready_and
  );

endinterface

// File: design/mem_port_arbiter.sv
`timescale 1ns/100ps
`include "bridge_defines.svh"

module mem_port_arbiter (
  input logic        clk_i,
  input logic        arst_n_i,
  mem_link_if.server port0_link,
  mem_link_if.server port1_link,
  mem_link_if.client master_link
);

  logic [`BRIDGE_NUM_PORTS-1:0] req;
  logic [`BRIDGE_NUM_PORTS-1:0] gnt;
  logic                         prio_r;
  logic                         busy_r;
  logic                         owner_r;
  logic                         fwd_fire;
  logic                         rev_fire;

  assign req = {port1_link.fwd_v, port0_link.fwd_v};

  // Round robin, only between transactions
  always_comb
  begin
    gnt = '0;
    if (!busy_r)
    begin
      if (req[prio_r])
        gnt[prio_r] = 1'b1;
      else if (req[~prio_r])
        gnt[~prio_r] = 1'b1;
    end
  end

  assign master_link.fwd_v      = |gnt;
  assign master_link.fwd_header = gnt[1] ? port1_link.fwd_header : port0_link.fwd_header;
  assign master_link.fwd_data   = gnt[1] ? port1_link.fwd_data : port0_link.fwd_data;

  assign port0_link.fwd_ready_and = gnt[0] && master_link.fwd_ready_and;
  assign port1_link.fwd_ready_and = gnt[1] && master_link.fwd_ready_and;

  // Response steered to the owner only
  assign port0_link.rev_header = master_link.rev_header;
  assign port0_link.rev_data   = master_link.rev_data;
  assign port0_link.rev_v      = master_link.rev_v && busy_r && !owner_r;
  assign port1_link.rev_header = master_link.rev_header;
  assign port1_link.rev_data   = master_link.rev_data;
  assign port1_link.rev_v      = master_link.rev_v && busy_r && owner_r;

  assign master_link.rev_ready_and = owner_r ? port1_link.rev_ready_and
                                             : port0_link.rev_ready_and;

  assign fwd_fire = master_link.fwd_v && master_link.fwd_ready_and;
  assign rev_fire = master_link.rev_v && master_link.rev_ready_and;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r  <= 1'b0;
      owner_r <= 1'b0;
      prio_r  <= 1'b0;
    end
    else if (fwd_fire)
    begin
      busy_r  <= 1'b1;
      owner_r <= gnt[1];
      // Other port goes first next time
      prio_r  <= ~gnt[1];
    end
    else if (rev_fire)
    begin
      busy_r  <= 1'b0;
      owner_r <= 1'b0;
    end
  end

  a_single_fwd_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(port0_link.fwd_ready_and && port1_link.fwd_ready_and));

  a_rev_needs_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    master_link.rev_v |-> busy_r);

endmodule

// File: axil_master/axil_master.sv
`timescale 1ns/100ps
`include "bridge_defines.svh"

module axil_master (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  mem_link_if.server                req_link,

  output logic [`BRIDGE_ADDR_W-1:0] m_axil_awaddr_o,
  output logic [2:0]                m_axil_awprot_o,
  output logic                      m_axil_awvalid_o,
  input  logic                      m_axil_awready_i,

  output logic [`BRIDGE_DATA_W-1:0] m_axil_wdata_o,
  output logic [`BRIDGE_STRB_W-1:0] m_axil_wstrb_o,
  output logic                      m_axil_wvalid_o,
  input  logic                      m_axil_wready_i,

  input  logic [1:0]                m_axil_bresp_i,
  input  logic                      m_axil_bvalid_i,
  output logic                      m_axil_bready_o,

  output logic [`BRIDGE_ADDR_W-1:0] m_axil_araddr_o,
  output logic [2:0]                m_axil_arprot_o,
  output logic                      m_axil_arvalid_o,
  input  logic                      m_axil_arready_i,

  input  logic [`BRIDGE_DATA_W-1:0] m_axil_rdata_i,
  input  logic [1:0]                m_axil_rresp_i,
  input  logic                      m_axil_rvalid_i,
  output logic                      m_axil_rready_o
);

  axil_pkg::axil_state_e        state_r;
  axil_pkg::axil_state_e        state_n;
  mem_msg_pkg::mem_fwd_header_s hdr_r;
  mem_msg_pkg::mem_rev_header_s rev_hdr;
  mem_msg_pkg::mem_resp_e       resp_r;
  logic [`BRIDGE_DATA_W-1:0]    data_r;
  logic [`BRIDGE_DATA_W-1:0]    rev_data_r;
  logic [`BRIDGE_DATA_W-1:0]    wdata_rep;
  logic [`BRIDGE_DATA_W-1:0]    data_mask;
  logic [`BRIDGE_STRB_W-1:0]    size_mask;
  logic [1:0]                   byte_off;
  logic                         ready_r;
  logic                         aw_done_r;
  logic                         w_done_r;
  logic                         fwd_fire;
  logic                         is_write;
  logic                         aw_fire;
  logic                         w_fire;
  logic                         b_err;
  logic                         r_err;

  assign fwd_fire = req_link.fwd_v && ready_r;
  assign is_write = req_link.fwd_header.opcode inside
                    {mem_msg_pkg::e_mem_wr, mem_msg_pkg::e_mem_uc_wr};
  assign aw_fire  = m_axil_awvalid_o && m_axil_awready_i;
  assign w_fire   = m_axil_wvalid_o && m_axil_wready_i;

  assign b_err = (m_axil_bresp_i == axil_pkg::e_axil_slverr)
              || (m_axil_bresp_i == axil_pkg::e_axil_decerr);
  assign r_err = (m_axil_rresp_i == axil_pkg::e_axil_slverr)
              || (m_axil_rresp_i == axil_pkg::e_axil_decerr);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      axil_pkg::e_st_idle:
        if (fwd_fire)
          state_n = is_write ? axil_pkg::e_st_write_req : axil_pkg::e_st_read_req;
      // AW and W may complete in either order
      axil_pkg::e_st_write_req:
        if ((aw_done_r || aw_fire) && (w_done_r || w_fire))
          state_n = axil_pkg::e_st_write_resp;
      axil_pkg::e_st_write_resp:
        if (m_axil_bvalid_i)
          state_n = axil_pkg::e_st_rev_out;
      axil_pkg::e_st_read_req:
        if (m_axil_arready_i)
          state_n = axil_pkg::e_st_read_resp;
      axil_pkg::e_st_read_resp:
        if (m_axil_rvalid_i)
          state_n = axil_pkg::e_st_rev_out;
      axil_pkg::e_st_rev_out:
        if (req_link.rev_ready_and)
          state_n = axil_pkg::e_st_idle;
      default:
        state_n = axil_pkg::e_st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r   <= axil_pkg::e_st_idle;
      ready_r   <= 1'b0;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      ready_r <= (state_n == axil_pkg::e_st_idle);
      if (state_n != axil_pkg::e_st_write_req)
      begin
        aw_done_r <= 1'b0;
        w_done_r  <= 1'b0;
      end
      else
      begin
        if (aw_fire)
          aw_done_r <= 1'b1;
        if (w_fire)
          w_done_r <= 1'b1;
      end
    end
  end

  // Lane masks and write data replication per size
  assign byte_off = hdr_r.addr[1:0];

  always_comb
  begin
    case (hdr_r.size)
      mem_msg_pkg::e_size_1:
      begin
        size_mask = 4'b0001;
        data_mask = 32'h0000_00ff;
        wdata_rep = {4{data_r[7:0]}};
      end
      mem_msg_pkg::e_size_2:
      begin
        size_mask = 4'b0011;
        data_mask = 32'h0000_ffff;
        wdata_rep = {2{data_r[15:0]}};
      end
      default:
      begin
        size_mask = 4'b1111;
        data_mask = 32'hffff_ffff;
        wdata_rep = data_r;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      hdr_r  <= req_link.fwd_header;
      data_r <= req_link.fwd_data;
    end
    if ((state_r == axil_pkg::e_st_write_resp) && m_axil_bvalid_i)
    begin
      resp_r     <= b_err ? mem_msg_pkg::e_resp_error : mem_msg_pkg::e_resp_ok;
      rev_data_r <= '0;
    end
    if ((state_r == axil_pkg::e_st_read_resp) && m_axil_rvalid_i)
    begin
      resp_r     <= r_err ? mem_msg_pkg::e_resp_error : mem_msg_pkg::e_resp_ok;
      // Requested bytes moved down to lane 0
      rev_data_r <= (m_axil_rdata_i >> {byte_off, 3'b000}) & data_mask;
    end
  end

  assign m_axil_awaddr_o  = hdr_r.addr;
  assign m_axil_awprot_o  = 3'b000;
  assign m_axil_awvalid_o = (state_r == axil_pkg::e_st_write_req) && !aw_done_r;
  assign m_axil_wdata_o   = wdata_rep;
  assign m_axil_wstrb_o   = size_mask << byte_off;
  assign m_axil_wvalid_o  = (state_r == axil_pkg::e_st_write_req) && !w_done_r;
  assign m_axil_bready_o  = (state_r == axil_pkg::e_st_write_resp);
  assign m_axil_araddr_o  = hdr_r.addr;
  assign m_axil_arprot_o  = 3'b000;
  assign m_axil_arvalid_o = (state_r == axil_pkg::e_st_read_req);
  assign m_axil_rready_o  = (state_r == axil_pkg::e_st_read_resp);

  always_comb
  begin
    rev_hdr.opcode = hdr_r.opcode;
    rev_hdr.size   = hdr_r.size;
    rev_hdr.addr   = hdr_r.addr;
    rev_hdr.resp   = resp_r;
  end

  assign req_link.fwd_ready_and = ready_r;
  assign req_link.rev_header    = rev_hdr;
  assign req_link.rev_data      = rev_data_r;
  assign req_link.rev_v         = (state_r == axil_pkg::e_st_rev_out);

  a_awaddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (m_axil_awvalid_o && !m_axil_awready_i)
      |=> (m_axil_awvalid_o && $stable(m_axil_awaddr_o)));

  // New request only with the bus and reverse channel quiet
  a_one_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_link.fwd_ready_and |-> !(m_axil_awvalid_o || m_axil_wvalid_o
      || m_axil_arvalid_o || m_axil_bready_o || m_axil_rready_o || req_link.rev_v));

endmodule

// File: design/axil_bridge_top.sv
`timescale 1ns/100ps
`include "bridge_defines.svh"

module axil_bridge_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  mem_msg_pkg::mem_fwd_header_s p0_fwd_header_i,
  input  logic [`BRIDGE_DATA_W-1:0]    p0_fwd_data_i,
  input  logic                         p0_fwd_v_i,
  output logic                         p0_fwd_ready_and_o,
  output mem_msg_pkg::mem_rev_header_s p0_rev_header_o,
  output logic [`BRIDGE_DATA_W-1:0]    p0_rev_data_o,
  output logic                         p0_rev_v_o,
  input  logic                         p0_rev_ready_and_i,

  input  mem_msg_pkg::mem_fwd_header_s p1_fwd_header_i,
  input  logic [`BRIDGE_DATA_W-1:0]    p1_fwd_data_i,
  input  logic                         p1_fwd_v_i,
  output logic                         p1_fwd_ready_and_o,
  output mem_msg_pkg::mem_rev_header_s p1_rev_header_o,
  output logic [`BRIDGE_DATA_W-1:0]    p1_rev_data_o,
  output logic                         p1_rev_v_o,
  input  logic                         p1_rev_ready_and_i,

  output logic [`BRIDGE_ADDR_W-1:0]    m_axil_awaddr_o,
  output logic [2:0]                   m_axil_awprot_o,
  output logic                         m_axil_awvalid_o,
  input  logic                         m_axil_awready_i,
  output logic [`BRIDGE_DATA_W-1:0]    m_axil_wdata_o,
  output logic [`BRIDGE_STRB_W-1:0]    m_axil_wstrb_o,
  output logic                         m_axil_wvalid_o,
  input  logic                         m_axil_wready_i,
  input  logic [1:0]                   m_axil_bresp_i,
  input  logic                         m_axil_bvalid_i,
  output logic                         m_axil_bready_o,
  output logic [`BRIDGE_ADDR_W-1:0]    m_axil_araddr_o,
  output logic [2:0]                   m_axil_arprot_o,
  output logic                         m_axil_arvalid_o,
  input  logic                         m_axil_arready_i,
  input  logic [`BRIDGE_DATA_W-1:0]    m_axil_rdata_i,
  input  logic [1:0]                   m_axil_rresp_i,
  input  logic                         m_axil_rvalid_i,
  output logic                         m_axil_rready_o
);

  mem_link_if p0_link ();
  mem_link_if p1_link ();
  mem_link_if mst_link ();

  // Port 0 client side
  assign p0_link.fwd_header    = p0_fwd_header_i;
  assign p0_link.fwd_data      = p0_fwd_data_i;
  assign p0_link.fwd_v         = p0_fwd_v_i;
  assign p0_link.rev_ready_and = p0_rev_ready_and_i;
  assign p0_fwd_ready_and_o    = p0_link.fwd_ready_and;
  assign p0_rev_header_o       = p0_link.rev_header;
  assign p0_rev_data_o         = p0_link.rev_data;
  assign p0_rev_v_o            = p0_link.rev_v;

  // Port 1 client side
  assign p1_link.fwd_header    = p1_fwd_header_i;
  assign p1_link.fwd_data      = p1_fwd_data_i;
  assign p1_link.fwd_v         = p1_fwd_v_i;
  assign p1_link.rev_ready_and = p1_rev_ready_and_i;
  assign p1_fwd_ready_and_o    = p1_link.fwd_ready_and;
  assign p1_rev_header_o       = p1_link.rev_header;
  assign p1_rev_data_o         = p1_link.rev_data;
  assign p1_rev_v_o            = p1_link.rev_v;

  mem_port_arbiter mem_port_arbiter_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .port0_link  (p0_link),
    .port1_link  (p1_link),
    .master_link (mst_link)
  );

  axil_master axil_master_i (
    .req_link (mst_link),
    .*
  );

endmodule

// File: testbench/tb_axil_bridge.sv
`timescale 1ns/100ps
`include "bridge_defines.svh"

module tb_axil_bridge;

  localparam int VEC_LEN = 384;
  localparam int TIMEOUT = 200;

  logic                         clk;
  logic                         arst_n;
  mem_msg_pkg::mem_fwd_header_s fwd_header [2];
  logic [`BRIDGE_DATA_W-1:0]    fwd_data [2];
  logic                         fwd_v [2];
  logic                         fwd_ready_and [2];
  mem_msg_pkg::mem_rev_header_s rev_header [2];
  logic [`BRIDGE_DATA_W-1:0]    rev_data [2];
  logic                         rev_v [2];
  logic                         rev_ready_and [2];

  logic [`BRIDGE_ADDR_W-1:0] awaddr;
  logic [2:0]                awprot;
  logic                      awvalid;
  logic                      awready = 1'b0;
  logic [`BRIDGE_DATA_W-1:0] wdata;
  logic [`BRIDGE_STRB_W-1:0] wstrb;
  logic                      wvalid;
  logic                      wready = 1'b0;
  logic [1:0]                bresp = 2'b00;
  logic                      bvalid = 1'b0;
  logic                      bready;
  logic [`BRIDGE_ADDR_W-1:0] araddr;
  logic [2:0]                arprot;
  logic                      arvalid;
  logic                      arready = 1'b0;
  logic [`BRIDGE_DATA_W-1:0] rdata = '0;
  logic [1:0]                rresp = 2'b00;
  logic                      rvalid = 1'b0;
  logic                      rready;

  // Slave memory and the handshakes seen at the last rising edge
  logic [`BRIDGE_DATA_W-1:0] slv_mem [64];
  logic [`BRIDGE_ADDR_W-1:0] slv_awaddr;
  logic [`BRIDGE_ADDR_W-1:0] slv_araddr;
  logic [`BRIDGE_DATA_W-1:0] slv_wdata;
  logic [`BRIDGE_STRB_W-1:0] slv_wstrb;
  bit                        aw_seen;
  bit                        w_seen;
  bit                        b_seen;
  bit                        ar_seen;
  bit                        r_seen;
  bit                        have_aw;
  bit                        have_w;
  bit                        have_ar;
  bit                        aw_roll;
  bit                        w_roll;
  bit                        ar_roll;
  bit                        rev_roll [2];

  logic [31:0] vec [VEC_LEN];
  int          grant_log [$];
  int          last_port;
  bit          stall_en;

  axil_bridge_top axil_bridge_top_i (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .p0_fwd_header_i    (fwd_header[0]),
    .p0_fwd_data_i      (fwd_data[0]),
    .p0_fwd_v_i         (fwd_v[0]),
    .p0_fwd_ready_and_o (fwd_ready_and[0]),
    .p0_rev_header_o    (rev_header[0]),
    .p0_rev_data_o      (rev_data[0]),
    .p0_rev_v_o         (rev_v[0]),
    .p0_rev_ready_and_i (rev_ready_and[0]),
    .p1_fwd_header_i    (fwd_header[1]),
    .p1_fwd_data_i      (fwd_data[1]),
    .p1_fwd_v_i         (fwd_v[1]),
    .p1_fwd_ready_and_o (fwd_ready_and[1]),
    .p1_rev_header_o    (rev_header[1]),
    .p1_rev_data_o      (rev_data[1]),
    .p1_rev_v_o         (rev_v[1]),
    .p1_rev_ready_and_i (rev_ready_and[1]),
    .m_axil_awaddr_o    (awaddr),
    .m_axil_awprot_o    (awprot),
    .m_axil_awvalid_o   (awvalid),
    .m_axil_awready_i   (awready),
    .m_axil_wdata_o     (wdata),
    .m_axil_wstrb_o     (wstrb),
    .m_axil_wvalid_o    (wvalid),
    .m_axil_wready_i    (wready),
    .m_axil_bresp_i     (bresp),
    .m_axil_bvalid_i    (bvalid),
    .m_axil_bready_o    (bready),
    .m_axil_araddr_o    (araddr),
    .m_axil_arprot_o    (arprot),
    .m_axil_arvalid_o   (arvalid),
    .m_axil_arready_i   (arready),
    .m_axil_rdata_i     (rdata),
    .m_axil_rresp_i     (rresp),
    .m_axil_rvalid_i    (rvalid),
    .m_axil_rready_o    (rready)
  );

  initial
    clk = 1'b0;

  always #2 clk = ~clk;

  function automatic bit pick_ready();
    if (!stall_en)
      return 1'b1;
    return ($urandom % 4) != 0;
  endfunction

  // Handshakes and ready draws at each rising edge
  initial
  begin
    void'($urandom(32'hd8eb));
    forever
    begin
      @(posedge clk);
      aw_seen = awvalid && awready;
      w_seen  = wvalid && wready;
      b_seen  = bvalid && bready;
      ar_seen = arvalid && arready;
      r_seen  = rvalid && rready;
      if (aw_seen)
      begin
        slv_awaddr = awaddr;
        check_prot("AW", awprot, 3'b000);
      end
      if (w_seen)
      begin
        slv_wdata = wdata;
        slv_wstrb = wstrb;
      end
      if (ar_seen)
      begin
        slv_araddr = araddr;
        check_prot("AR", arprot, 3'b000);
      end
      aw_roll     = pick_ready();
      w_roll      = pick_ready();
      ar_roll     = pick_ready();
      rev_roll[0] = pick_ready();
      rev_roll[1] = pick_ready();
    end
  end

  always @(negedge clk)
  begin
    if (aw_seen)
      have_aw = 1'b1;
    if (w_seen)
      have_w = 1'b1;
    if (ar_seen)
      have_ar = 1'b1;
    if (b_seen)
      bvalid = 1'b0;
    if (r_seen)
      rvalid = 1'b0;
    if (have_aw && have_w && !bvalid)
    begin
      if (slv_awaddr < 32'h100)
      begin
        for (int b = 0; b < `BRIDGE_STRB_W; b++)
          if (slv_wstrb[b])
            slv_mem[slv_awaddr[7:2]][8*b +: 8] = slv_wdata[8*b +: 8];
        bresp = axil_pkg::e_axil_okay;
      end
      else
        bresp = axil_pkg::e_axil_slverr;
      bvalid  = 1'b1;
      have_aw = 1'b0;
      have_w  = 1'b0;
    end
    if (have_ar && !rvalid)
    begin
      if (slv_araddr < 32'h100)
      begin
        rdata = slv_mem[slv_araddr[7:2]];
        rresp = axil_pkg::e_axil_okay;
      end
      else
      begin
        rdata = '0;
        rresp = axil_pkg::e_axil_slverr;
      end
      rvalid  = 1'b1;
      have_ar = 1'b0;
    end
    awready = !have_aw && aw_roll;
    wready  = !have_w && w_roll;
    arready = !have_ar && ar_roll;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_rev_header(input int p, input mem_msg_pkg::mem_rev_header_s got,
                                  input mem_msg_pkg::mem_rev_header_s exp);
    if (got.opcode !== exp.opcode || got.size !== exp.size || got.addr !== exp.addr)
      stop_with_failure($sformatf("Fail %0t: port %0d header %0d/%0d/%h, expected %0d/%0d/%h",
        $time, p, got.opcode, got.size, got.addr, exp.opcode, exp.size, exp.addr));
  endtask

  task automatic check_rev_data(input int p, input logic [`BRIDGE_DATA_W-1:0] got,
                                input logic [`BRIDGE_DATA_W-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("Fail %0t: port %0d data %h, expected %h",
        $time, p, got, exp));
  endtask

  task automatic check_resp(input int p, input mem_msg_pkg::mem_resp_e got,
                            input mem_msg_pkg::mem_resp_e exp);
    if (got !== exp)
      stop_with_failure($sformatf("Fail %0t: port %0d resp %0d, expected %0d",
        $time, p, got, exp));
  endtask

  task automatic check_prot(input string ch, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("Fail %0t: %s prot %b, expected %b",
        $time, ch, got, exp));
  endtask

  // One request on port p and its reverse beat
  task automatic run_port(input int p, input mem_msg_pkg::mem_fwd_header_s hdr,
                          input logic [`BRIDGE_DATA_W-1:0] wr_data,
                          input logic [`BRIDGE_DATA_W-1:0] exp_data, input bit solo);
    mem_msg_pkg::mem_rev_header_s exp_hdr;
    mem_msg_pkg::mem_rev_header_s got_hdr;
    logic [`BRIDGE_DATA_W-1:0]    got_data;
    int                           waited;
    bit                           done;
    exp_hdr.opcode = hdr.opcode;
    exp_hdr.size   = hdr.size;
    exp_hdr.addr   = hdr.addr;
    exp_hdr.resp   = (hdr.addr >= 32'h100) ? mem_msg_pkg::e_resp_error
                                           : mem_msg_pkg::e_resp_ok;
    @(negedge clk);
    fwd_header[p] = hdr;
    fwd_data[p]   = wr_data;
    fwd_v[p]      = 1'b1;
    waited = 0;
    done   = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (fwd_ready_and[p])
        done = 1'b1;
      else
      begin
        waited++;
        if (waited >= TIMEOUT)
          stop_with_failure($sformatf("Timeout: port %0d request was never accepted", p));
      end
    end
    grant_log.push_back(p);
    @(negedge clk);
    fwd_v[p] = 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done)
    begin
      rev_ready_and[p] = rev_roll[p];
      @(posedge clk);
      if (solo && rev_v[1-p])
        stop_with_failure($sformatf("Port %0d got a response it never asked for", 1 - p));
      if (rev_v[p] && rev_ready_and[p])
      begin
        got_hdr  = rev_header[p];
        got_data = rev_data[p];
        done     = 1'b1;
      end
      else
      begin
        waited++;
        if (waited >= TIMEOUT)
          stop_with_failure($sformatf("Timeout: port %0d reverse beat never came", p));
      end
      @(negedge clk);
    end
    rev_ready_and[p] = 1'b0;
    check_rev_header(p, got_hdr, exp_hdr);
    check_resp(p, got_hdr.resp, exp_hdr.resp);
    check_rev_data(p, got_data, exp_data);
  endtask

  // Same read on both ports at once
  task automatic run_both(input mem_msg_pkg::mem_fwd_header_s hdr,
                          input logic [`BRIDGE_DATA_W-1:0] exp_data);
    int first;
    first = 1 - last_port;
    grant_log.delete();
    fork
      run_port(0, hdr, '0, exp_data, 1'b0);
      run_port(1, hdr, '0, exp_data, 1'b0);
    join
    if (grant_log[0] != first)
      stop_with_failure($sformatf("Fail %0t: port %0d granted first, expected port %0d",
        $time, grant_log[0], first));
    last_port = grant_log[1];
  endtask

  task automatic run_file(input bit swap_ports);
    int                           idx;
    int                           p;
    mem_msg_pkg::mem_fwd_header_s hdr;
    idx = 0;
    while (idx + 5 < VEC_LEN && vec[idx] !== 32'hff)
    begin
      p          = vec[idx];
      hdr.opcode = mem_msg_pkg::mem_opcode_e'(vec[idx+1][1:0]);
      hdr.size   = mem_msg_pkg::mem_size_e'(vec[idx+2][1:0]);
      hdr.addr   = vec[idx+3];
      if (p == 2)
        run_both(hdr, vec[idx+5]);
      else if (p == 0 || p == 1)
      begin
        if (swap_ports)
          p = 1 - p;
        run_port(p, hdr, vec[idx+4], vec[idx+5], 1'b1);
        last_port = p;
      end
      else
        stop_with_failure($sformatf("Test data holds an unknown port value %0d", p));
      idx += 6;
    end
  endtask

  initial
  begin
    for (int i = 0; i < 2; i++)
    begin
      fwd_header[i]    = '0;
      fwd_data[i]      = '0;
      fwd_v[i]         = 1'b0;
      rev_ready_and[i] = 1'b0;
    end
    arst_n    = 1'b0;
    stall_en  = 1'b0;
    last_port = 1;
    for (int i = 0; i < 64; i++)
      slv_mem[i] = 32'h5a00_0000 ^ (i * 32'h0104_0201);
    $readmemh("testbench/axil_bridge_testdata.txt", vec);
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    // Second pass swaps the single-port lines and adds bus stalls and back-pressure
    for (int pass = 0; pass < 2; pass++)
    begin
      stall_en = (pass == 1);
      run_file(pass == 1);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: project.f
+incdir+common
common/mem_msg_pkg.sv
common/axil_pkg.sv
common/mem_link_if.sv
design/mem_port_arbiter.sv
axil_master/axil_master.sv
design/axil_bridge_top.sv
testbench/tb_axil_bridge.sv

// File: run.sh
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_axil_bridge -f project.f -o Vtb_axil_bridge

status=0
./obj_dir/Vtb_axil_bridge > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^RESULT: PASS$" sim.log
then
  echo "simulation passed, exit status $status"
  exit 0
fi
echo "simulation failed, exit status $status"
exit 1

// File: testbench/axil_bridge_testdata.txt
// port opcode size addr wdata expected_rdata, all hex
// port 2 issues the read on both ports together, port ff ends the list
0 1 2 00000010 cafef00d 00000000
0 0 2 00000010 00000000 cafef00d
1 3 2 00000020 11223344 00000000
1 2 2 00000020 00000000 11223344
0 1 0 00000020 123456aa 00000000
1 1 0 00000021 000000bb 00000000
0 3 0 00000022 ffffffcc 00000000
1 1 0 00000023 000000dd 00000000
0 0 2 00000020 00000000 ddccbbaa
1 0 0 00000022 00000000 000000cc
0 1 2 00000030 00000000 00000000
1 1 1 00000030 9999beef 00000000
0 1 1 00000032 0000dead 00000000
1 0 2 00000030 00000000 deadbeef
0 0 0 00000031 00000000 000000be
1 2 0 00000033 00000000 000000de
0 0 1 00000032 00000000 0000dead
1 0 1 00000030 00000000 0000beef
2 0 2 00000010 00000000 cafef00d
2 2 2 00000030 00000000 deadbeef
0 1 2 00000100 12345678 00000000
1 0 2 00000104 00000000 00000000
1 3 0 00000fff 000000ee 00000000
0 2 2 00000200 00000000 00000000
ff 0 0 0 0 0
